// File: src/ranging_pkg.sv
package ranging_pkg;

   //////////////////////////////
   // sensor array geometry
   //////////////////////////////

   // number of ultrasonic sensor ports on the board
   localparam int NUM_SENSORS      = 6;
   localparam int SENSOR_ID_WIDTH  = 3;
   localparam int DISTANCE_WIDTH   = 8;
   // wide enough for a full 38 ms echo at 27 MHz
   localparam int ECHO_COUNT_WIDTH = 20;

   // one bit per sensor for trigger, power, echo and mask
   typedef logic [NUM_SENSORS-1:0]      sensor_bus_t;
   typedef logic [SENSOR_ID_WIDTH-1:0]  sensor_id_t;
   // distance in inches
   typedef logic [DISTANCE_WIDTH-1:0]   distance_t;
   typedef logic [ECHO_COUNT_WIDTH-1:0] echo_count_t;

   //////////////////////////////
   // distance encoding
   //////////////////////////////

   // reported when the echo never comes back low
   localparam distance_t NOTHING_FOUND   = distance_t'(255);
   // largest real distance, one below the timeout code
   localparam distance_t MAX_DISTANCE    = distance_t'(254);
   // fixed inches added after the shift
   localparam distance_t DISTANCE_OFFSET = distance_t'(5);

   //////////////////////////////
   // device timing at 27 MHz
   //////////////////////////////

   // a little over 10 us of trigger
   localparam int DEFAULT_TRIGGER_CYCLES   = 275;
   // about 38 ms of echo means nothing in range
   localparam int DEFAULT_ECHO_TIMEOUT     = 1048576;
   // one second with power removed clears a hung sensor
   localparam int DEFAULT_POWER_OFF_CYCLES = 27000000;
   // 148 us per inch is ~3996 cycles so divide by 4096
   localparam int DEFAULT_INCH_SHIFT       = 12;

   // ranger FSM
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_TRIGGER,
      ST_WAIT_RISE,
      ST_COUNT_ECHO,
      ST_POWER_OFF,
      ST_REPORT
   } ranger_state_t;

endpackage

// File: src/hcsr04_ranger.sv
`timescale 1ns/1ns

module hcsr04_ranger import ranging_pkg::*; #(
   parameter int TRIGGER_CYCLES   = DEFAULT_TRIGGER_CYCLES,
   parameter int ECHO_TIMEOUT     = DEFAULT_ECHO_TIMEOUT,
   parameter int POWER_OFF_CYCLES = DEFAULT_POWER_OFF_CYCLES,
   parameter int INCH_SHIFT       = DEFAULT_INCH_SHIFT
) (
   input  logic        clock,
   input  logic        reset,
   input  logic        measure_start,
   input  sensor_id_t  sensor_sel,
   input  sensor_bus_t echo,
   output sensor_bus_t trigger,
   output sensor_bus_t power,
   output distance_t   distance,
   output logic        measure_done
);

   // one timer serves both the trigger pulse and the power-off interval
   localparam int TIMER_LIMIT = (POWER_OFF_CYCLES > TRIGGER_CYCLES) ?
                                POWER_OFF_CYCLES : TRIGGER_CYCLES;
   localparam int TIMER_WIDTH = $clog2(TIMER_LIMIT + 1);

   typedef logic [TIMER_WIDTH-1:0] timer_t;

   ranger_state_t state;

   // echo pins are asynchronous to our clock
   sensor_bus_t echo_meta;
   sensor_bus_t echo_sync;
   logic        echo_level;

   echo_count_t echo_count;
   echo_count_t echo_shifted;
   logic        echo_zero;
   logic        echo_timeout;
   distance_t   echo_inches;

   timer_t      timer;
   // converted value waiting for the report state, zero asks for a retry
   distance_t   result;

   //////////////////////////////
   // echo synchronizer
   //////////////////////////////

   // two flops on the whole bus so a sensor switch needs no refill
   always_ff @(posedge clock) begin
      if (reset) begin
         echo_meta <= '0;
         echo_sync <= '0;
      end else begin
         echo_meta <= echo;
         echo_sync <= echo_meta;
      end
   end

   // only the selected sensor matters
   assign echo_level = echo_sync[sensor_sel];

   // still high on the cycle that would make the count reach the limit
   assign echo_timeout = echo_level && (echo_count == echo_count_t'(ECHO_TIMEOUT - 1));

   //////////////////////////////
   // count to inches
   //////////////////////////////

   always_comb begin
      echo_shifted = echo_count >> INCH_SHIFT;
      // a short echo shifts to nothing and is retried
      echo_zero    = (echo_shifted == '0);
      // clamp below the nothing-found code
      if (echo_shifted > echo_count_t'(MAX_DISTANCE - DISTANCE_OFFSET)) begin
         echo_inches = MAX_DISTANCE;
      end else begin
         echo_inches = distance_t'(echo_shifted) + DISTANCE_OFFSET;
      end
   end

   //////////////////////////////
   // measurement FSM
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state        <= ST_IDLE;
         trigger      <= '0;
         // sensors come up powered
         power        <= '1;
         measure_done <= 1'b0;
         timer        <= '0;
         echo_count   <= '0;
      end else begin
         // done is a single strobe
         measure_done <= 1'b0;
         case (state)
            ST_IDLE: begin
               // trigger rises the cycle after the request
               if (measure_start) begin
                  trigger[sensor_sel] <= 1'b1;
                  timer               <= timer_t'(1);
                  state               <= ST_TRIGGER;
               end
            end

            ST_TRIGGER: begin
               // hold the pin for exactly TRIGGER_CYCLES
               if (timer == timer_t'(TRIGGER_CYCLES)) begin
                  trigger[sensor_sel] <= 1'b0;
                  state               <= ST_WAIT_RISE;
               end else begin
                  timer <= timer + timer_t'(1);
               end
            end

            ST_WAIT_RISE: begin
               // no limit here, the sensor answers when it answers
               if (echo_level) begin
                  echo_count <= echo_count_t'(1);
                  state      <= ST_COUNT_ECHO;
               end
            end

            ST_COUNT_ECHO: begin
               if (!echo_level) begin
                  // falling edge, the converted value is latched below
                  state <= ST_REPORT;
               end else if (echo_timeout) begin
                  // hung sensor gets its supply pulled
                  power[sensor_sel] <= 1'b0;
                  timer             <= timer_t'(1);
                  state             <= ST_POWER_OFF;
               end else begin
                  echo_count <= echo_count + echo_count_t'(1);
               end
            end

            ST_POWER_OFF: begin
               if (timer == timer_t'(POWER_OFF_CYCLES)) begin
                  power[sensor_sel] <= 1'b1;
                  state             <= ST_REPORT;
               end else begin
                  timer <= timer + timer_t'(1);
               end
            end

            ST_REPORT: begin
               if (result == '0) begin
                  // zero inches is not a real answer so fire again
                  trigger[sensor_sel] <= 1'b1;
                  timer               <= timer_t'(1);
                  state               <= ST_TRIGGER;
               end else begin
                  measure_done <= 1'b1;
                  state        <= ST_IDLE;
               end
            end

            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   //////////////////////////////
   // result registers
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (state == ST_COUNT_ECHO) begin
         if (!echo_level) begin
            result <= echo_zero ? distance_t'(0) : echo_inches;
         end else if (echo_timeout) begin
            result <= NOTHING_FOUND;
         end
      end
      // distance is presented together with the done strobe
      if (state == ST_REPORT && result != '0) begin
         distance <= result;
      end
   end

endmodule

// File: src/sensor_scan.sv
`timescale 1ns/1ns

module sensor_scan import ranging_pkg::*; (
   input  logic        clock,
   input  logic        reset,
   input  logic        scan_start,
   input  sensor_bus_t sensor_mask,
   input  logic        measure_done,
   output logic        measure_start,
   output sensor_id_t  sensor_sel,
   output logic        scan_begin,
   output logic        scan_end,
   output logic        busy
);

   // scanner states, only used here
   typedef enum logic [1:0] {
      SCAN_IDLE,
      SCAN_SELECT,
      SCAN_WAIT
   } scan_state_t;

   scan_state_t state;

   // sensors of this scan still to be measured
   sensor_bus_t pending;
   sensor_id_t  next_sel;
   logic        next_valid;

   //////////////////////////////
   // next sensor lookup
   //////////////////////////////

   // lowest pending index wins so sensors go in index order
   always_comb begin
      next_sel = '0;
      for (int i = NUM_SENSORS - 1; i >= 0; i--) begin
         if (pending[i]) begin
            next_sel = sensor_id_t'(i);
         end
      end
   end

   assign next_valid = |pending;

   // busy covers the whole scan from acceptance until the end strobe
   assign busy = (state != SCAN_IDLE);

   //////////////////////////////
   // scan sequencer
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state         <= SCAN_IDLE;
         pending       <= '0;
         sensor_sel    <= '0;
         measure_start <= 1'b0;
         scan_begin    <= 1'b0;
         scan_end      <= 1'b0;
      end else begin
         // all three are one-cycle strobes
         measure_start <= 1'b0;
         scan_begin    <= 1'b0;
         scan_end      <= 1'b0;
         case (state)
            SCAN_IDLE: begin
               // mask is sampled once per scan
               if (scan_start) begin
                  pending    <= sensor_mask;
                  scan_begin <= 1'b1;
                  state      <= SCAN_SELECT;
               end
            end

            SCAN_SELECT: begin
               if (next_valid) begin
                  // sel stays put until the ranger is done
                  sensor_sel        <= next_sel;
                  measure_start     <= 1'b1;
                  pending[next_sel] <= 1'b0;
                  state             <= SCAN_WAIT;
               end else begin
                  // nothing left, an empty mask lands here right away
                  scan_end <= 1'b1;
                  state    <= SCAN_IDLE;
               end
            end

            SCAN_WAIT: begin
               if (measure_done) begin
                  state <= SCAN_SELECT;
               end
            end

            default: begin
               state <= SCAN_IDLE;
            end
         endcase
      end
   end

endmodule

// File: src/range_table.sv
`timescale 1ns/1ns

module range_table import ranging_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  logic       scan_begin,
   input  logic       scan_end,
   input  logic       measure_done,
   input  sensor_id_t sensor_sel,
   input  distance_t  distance,
   input  sensor_id_t range_sel,
   output distance_t  range_distance,
   output sensor_id_t nearest_sensor,
   output distance_t  nearest_distance,
   output logic       scan_done
);

   // latest result per sensor
   distance_t entry [NUM_SENSORS];

   // running minimum over the scan in progress
   distance_t  min_distance;
   sensor_id_t min_sensor;
   // set once the first result of the scan is in
   logic       min_valid;

   //////////////////////////////
   // per-sensor table
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         for (int i = 0; i < NUM_SENSORS; i++) begin
            entry[i] <= NOTHING_FOUND;
         end
      end else if (measure_done) begin
         entry[sensor_sel] <= distance;
      end
   end

   // read port is open at all times
   always_comb begin
      if (range_sel < sensor_id_t'(NUM_SENSORS)) begin
         range_distance = entry[range_sel];
      end else begin
         // unused indices look like empty sensors
         range_distance = NOTHING_FOUND;
      end
   end

   //////////////////////////////
   // nearest target search
   //////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         min_distance <= NOTHING_FOUND;
         min_sensor   <= '0;
         min_valid    <= 1'b0;
      end else if (scan_begin) begin
         min_distance <= NOTHING_FOUND;
         min_sensor   <= '0;
         min_valid    <= 1'b0;
      end else if (measure_done) begin
         // strict compare keeps the lower index on a tie
         // the first result always lands so an all-timeout scan
         // still names a sensor that was measured
         if (!min_valid || distance < min_distance) begin
            min_distance <= distance;
            min_sensor   <= sensor_sel;
         end
         min_valid <= 1'b1;
      end
   end

   // publish at end of scan, held until the next one
   always_ff @(posedge clock) begin
      if (reset) begin
         nearest_sensor   <= '0;
         nearest_distance <= NOTHING_FOUND;
         scan_done        <= 1'b0;
      end else begin
         scan_done <= scan_end;
         if (scan_end) begin
            nearest_sensor   <= min_sensor;
            nearest_distance <= min_distance;
         end
      end
   end

endmodule

// File: src/radar_ranging_top.sv
`timescale 1ns/1ns

module radar_ranging_top import ranging_pkg::*; #(
   // device timing in clock cycles
   parameter int TRIGGER_CYCLES   = DEFAULT_TRIGGER_CYCLES,
   parameter int ECHO_TIMEOUT     = DEFAULT_ECHO_TIMEOUT,
   parameter int POWER_OFF_CYCLES = DEFAULT_POWER_OFF_CYCLES,
   parameter int INCH_SHIFT       = DEFAULT_INCH_SHIFT
) (
   input  logic        clock,
   input  logic        reset,
   input  logic        scan_start,
   input  sensor_bus_t sensor_mask,
   input  sensor_bus_t echo,
   input  sensor_id_t  range_sel,
   output sensor_bus_t trigger,
   output sensor_bus_t power,
   output logic        busy,
   output logic        scan_done,
   output sensor_id_t  nearest_sensor,
   output distance_t   nearest_distance,
   output distance_t   range_distance
);

   //////////////////////////////
   // internal handshakes
   //////////////////////////////

   // scanner to ranger
   logic       measure_start;
   sensor_id_t sensor_sel;
   // ranger back to scanner and table
   logic       measure_done;
   distance_t  distance;
   // scan framing for the nearest search
   logic       scan_begin;
   logic       scan_end;

   // walks the enabled sensors one at a time
   sensor_scan u_scan (
      .clock         (clock),
      .reset         (reset),
      .scan_start    (scan_start),
      .sensor_mask   (sensor_mask),
      .measure_done  (measure_done),
      .measure_start (measure_start),
      .sensor_sel    (sensor_sel),
      .scan_begin    (scan_begin),
      .scan_end      (scan_end),
      .busy          (busy)
   );

   // single ranger shared by all sensors
   hcsr04_ranger #(
      .TRIGGER_CYCLES   (TRIGGER_CYCLES),
      .ECHO_TIMEOUT     (ECHO_TIMEOUT),
      .POWER_OFF_CYCLES (POWER_OFF_CYCLES),
      .INCH_SHIFT       (INCH_SHIFT)
   ) u_ranger (
      .clock         (clock),
      .reset         (reset),
      .measure_start (measure_start),
      .sensor_sel    (sensor_sel),
      .echo          (echo),
      .trigger       (trigger),
      .power         (power),
      .distance      (distance),
      .measure_done  (measure_done)
   );

   range_table u_table (
      .clock            (clock),
      .reset            (reset),
      .scan_begin       (scan_begin),
      .scan_end         (scan_end),
      .measure_done     (measure_done),
      .sensor_sel       (sensor_sel),
      .distance         (distance),
      .range_sel        (range_sel),
      .range_distance   (range_distance),
      .nearest_sensor   (nearest_sensor),
      .nearest_distance (nearest_distance),
      .scan_done        (scan_done)
   );

endmodule

// File: test/echo_model.sv
`timescale 1ns/1ns

module echo_model import ranging_pkg::*; (
   input  logic        clock,
   input  sensor_bus_t trigger,
   input  sensor_bus_t power,
   output sensor_bus_t echo
);

   // narrower than one inch after a shift of 2
   localparam int SHORT_WIDTH = 3;

   // per-sensor behavior, written by the testbench
   int echo_delay  [NUM_SENSORS];
   int echo_width  [NUM_SENSORS];
   // stuck echo stays high until power is pulled
   bit echo_stuck  [NUM_SENSORS];
   // next echo only is too short to give a distance
   bit short_first [NUM_SENSORS];

   // observations
   int trigger_count    [NUM_SENSORS];
   int trigger_width    [NUM_SENSORS];
   int power_low_cycles [NUM_SENSORS];
   // sensor index of every trigger pulse in arrival order
   int trigger_log [$];

   for (genvar g = 0; g < NUM_SENSORS; g++) begin : g_sensor
      logic level;

      assign echo[g] = level;

      initial begin : respond
         int high;
         int width;
         level = 1'b0;
         forever begin
            @(posedge trigger[g]);
            trigger_count[g]++;
            trigger_log.push_back(g);
            // pulse width in whole cycles, sampled mid-cycle
            high = 0;
            @(negedge clock);
            while (trigger[g]) begin
               high++;
               @(negedge clock);
            end
            trigger_width[g] = high;
            // echo starts a while after the burst is sent
            repeat (echo_delay[g]) @(negedge clock);
            level = 1'b1;
            if (echo_stuck[g]) begin
               // hung until the supply is removed
               @(negedge power[g]);
               @(negedge clock);
            end else begin
               width = short_first[g] ? SHORT_WIDTH : echo_width[g];
               short_first[g] = 1'b0;
               repeat (width) @(negedge clock);
            end
            level = 1'b0;
         end
      end

      // mid-cycle count of supply-off cycles
      always @(negedge clock) begin
         if (power[g] === 1'b0) begin
            power_low_cycles[g]++;
         end
      end
   end

endmodule

// File: test/tb_radar_ranging.sv
`timescale 1ns/1ns

module tb_radar_ranging import ranging_pkg::*; ();

   // short device timing
   localparam int TRIGGER_CYCLES   = 4;
   localparam int ECHO_TIMEOUT     = 200;
   localparam int POWER_OFF_CYCLES = 30;
   localparam int INCH_SHIFT       = 2;
   // 1 + 6 + 2 + 3 + 1 measurements over all tests
   localparam int MEASUREMENTS     = 13;
   localparam int WATCHDOG_CYCLES  = MEASUREMENTS * 400 + 2000;

   logic        clock;
   logic        reset;
   logic        scan_start;
   sensor_bus_t sensor_mask;
   sensor_id_t  range_sel;
   sensor_bus_t echo;
   sensor_bus_t trigger;
   sensor_bus_t power;
   logic        busy;
   logic        scan_done;
   sensor_id_t  nearest_sensor;
   distance_t   nearest_distance;
   distance_t   range_distance;

   logic [31:0] rng_state = 32'h131d;

   radar_ranging_top #(
      .TRIGGER_CYCLES   (TRIGGER_CYCLES),
      .ECHO_TIMEOUT     (ECHO_TIMEOUT),
      .POWER_OFF_CYCLES (POWER_OFF_CYCLES),
      .INCH_SHIFT       (INCH_SHIFT)
   ) dut (
      .clock            (clock),
      .reset            (reset),
      .scan_start       (scan_start),
      .sensor_mask      (sensor_mask),
      .echo             (echo),
      .range_sel        (range_sel),
      .trigger          (trigger),
      .power            (power),
      .busy             (busy),
      .scan_done        (scan_done),
      .nearest_sensor   (nearest_sensor),
      .nearest_distance (nearest_distance),
      .range_distance   (range_distance)
   );

   echo_model sensors (
      .clock   (clock),
      .trigger (trigger),
      .power   (power),
      .echo    (echo)
   );

   initial begin
      clock = 1'b0;
      forever #10 clock = ~clock;
   end

   // run is cut off if any handshake never arrives
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clock);
      $display("error: run timed out waiting for the DUT");
      $display("TESTBENCH FAILED");
      $fatal(1);
   end

   //////////////////////////////
   // helpers
   //////////////////////////////

   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng_state = x;
      return x;
   endfunction

   // inches = (cycles >> 2) + 5, capped at 254
   function automatic distance_t expected_distance(input int width);
      int inches;
      inches = (width >> INCH_SHIFT) + 5;
      if (inches > 254) begin
         inches = 254;
      end
      return distance_t'(inches);
   endfunction

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      assert (got === expected) else begin
         $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic check_true(input bit ok, input string what);
      assert (ok) else begin
         $display("error: %s", what);
         $display("TESTBENCH FAILED");
         $fatal(1);
      end
   endtask

   task automatic clear_model();
      for (int i = 0; i < NUM_SENSORS; i++) begin
         sensors.echo_stuck[i]       = 1'b0;
         sensors.short_first[i]      = 1'b0;
         sensors.trigger_count[i]    = 0;
         sensors.power_low_cycles[i] = 0;
      end
      sensors.trigger_log.delete();
   endtask

   task automatic program_sensor(input int idx, input int delay, input int width,
                                 input bit stuck, input bit short);
      sensors.echo_delay[idx]  = delay;
      sensors.echo_width[idx]  = width;
      sensors.echo_stuck[idx]  = stuck;
      sensors.short_first[idx] = short;
   endtask

   // one-cycle request, driven mid-cycle
   task automatic start_scan(input sensor_bus_t mask);
      @(negedge clock);
      sensor_mask = mask;
      scan_start  = 1'b1;
      @(negedge clock);
      scan_start  = 1'b0;
   endtask

   task automatic wait_scan_done();
      do @(negedge clock); while (scan_done !== 1'b1);
   endtask

   task automatic check_entry(input int idx, input distance_t expected);
      @(negedge clock);
      range_sel = sensor_id_t'(idx);
      @(negedge clock);
      check_equal($sformatf("range_distance[%0d]", idx), range_distance, expected);
   endtask

   //////////////////////////////
   // directed tests
   //////////////////////////////

   task automatic test_single_sensor();
      clear_model();
      program_sensor(3, 2, 37, 1'b0, 1'b0);
      start_scan(6'b001000);
      wait_scan_done();
      check_equal("nearest_sensor", nearest_sensor, 3);
      check_equal("nearest_distance", nearest_distance, expected_distance(37));
      check_entry(3, expected_distance(37));
      check_equal("trigger_count[3]", sensors.trigger_count[3], 1);
      check_equal("trigger_width[3]", sensors.trigger_width[3], TRIGGER_CYCLES);
   endtask

   task automatic test_full_scan();
      int         widths [NUM_SENSORS];
      distance_t  min_distance;
      sensor_id_t min_sensor;
      clear_model();
      for (int i = 0; i < NUM_SENSORS; i++) begin
         widths[i] = 12 + int'(next_random() % 170);
      end
      // sensors 1 and 4 tie on the smallest distance
      widths[1] = 8;
      widths[4] = 9;
      for (int i = 0; i < NUM_SENSORS; i++) begin
         program_sensor(i, 1 + i, widths[i], 1'b0, 1'b0);
      end
      start_scan(6'b111111);
      wait_scan_done();
      min_distance = NOTHING_FOUND;
      min_sensor   = '0;
      for (int i = 0; i < NUM_SENSORS; i++) begin
         if (expected_distance(widths[i]) < min_distance) begin
            min_distance = expected_distance(widths[i]);
            min_sensor   = sensor_id_t'(i);
         end
      end
      check_equal("nearest_sensor", nearest_sensor, min_sensor);
      check_equal("nearest_distance", nearest_distance, min_distance);
      check_equal("trigger pulses", sensors.trigger_log.size(), NUM_SENSORS);
      for (int i = 0; i < NUM_SENSORS; i++) begin
         check_equal($sformatf("trigger order %0d", i), sensors.trigger_log[i], i);
         check_entry(i, expected_distance(widths[i]));
      end
   endtask

   task automatic test_zero_result();
      clear_model();
      // short first echo forces a second trigger
      program_sensor(2, 3, 50, 1'b0, 1'b1);
      start_scan(6'b000100);
      wait_scan_done();
      check_equal("trigger_count[2]", sensors.trigger_count[2], 2);
      check_equal("trigger_width[2]", sensors.trigger_width[2], TRIGGER_CYCLES);
      check_equal("nearest_distance", nearest_distance, expected_distance(50));
      check_entry(2, expected_distance(50));
   endtask

   task automatic test_stuck_echo();
      clear_model();
      program_sensor(1, 2, 20, 1'b0, 1'b0);
      program_sensor(2, 2, 0, 1'b1, 1'b0);
      program_sensor(3, 2, 60, 1'b0, 1'b0);
      start_scan(6'b001110);
      wait_scan_done();
      // only the hung sensor loses power
      check_equal("power_low_cycles[2]", sensors.power_low_cycles[2], POWER_OFF_CYCLES);
      check_equal("power_low_cycles[1]", sensors.power_low_cycles[1], 0);
      check_equal("power_low_cycles[3]", sensors.power_low_cycles[3], 0);
      check_equal("power", power, 6'h3f);
      check_entry(2, NOTHING_FOUND);
      check_entry(1, expected_distance(20));
      check_entry(3, expected_distance(60));
      check_equal("nearest_sensor", nearest_sensor, 1);
      check_equal("nearest_distance", nearest_distance, expected_distance(20));
   endtask

   task automatic test_empty_and_busy();
      clear_model();
      start_scan(6'b000000);
      wait_scan_done();
      check_equal("nearest_distance", nearest_distance, NOTHING_FOUND);
      check_equal("nearest_sensor", nearest_sensor, 0);
      check_equal("trigger pulses", sensors.trigger_log.size(), 0);
      program_sensor(4, 2, 30, 1'b0, 1'b0);
      start_scan(6'b010000);
      check_true(busy === 1'b1, "busy is low right after an accepted scan_start");
      // request during a scan must be dropped
      start_scan(6'b111111);
      wait_scan_done();
      repeat (20) @(negedge clock);
      check_true(busy === 1'b0, "a scan_start given while busy started another scan");
      check_equal("trigger pulses", sensors.trigger_log.size(), 1);
      check_equal("nearest_distance", nearest_distance, expected_distance(30));
   endtask

   //////////////////////////////
   // main sequence
   //////////////////////////////

   initial begin
      reset       = 1'b1;
      scan_start  = 1'b0;
      sensor_mask = '0;
      range_sel   = '0;
      repeat (8) @(negedge clock);
      reset = 1'b0;
      test_single_sensor();
      test_full_scan();
      test_zero_result();
      test_stuck_echo();
      test_empty_and_busy();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

// File: radar_ranging.f
src/ranging_pkg.sv
src/hcsr04_ranger.sv
src/sensor_scan.sv
src/range_table.sv
src/radar_ranging_top.sv
test/echo_model.sv
test/tb_radar_ranging.sv
